/* src/uart_pkg.sv */
package uart_pkg;

    // ==========================================================
    // serial line types
    // ==========================================================

    // one data byte as it travels on the line.
    typedef logic [7:0] uart_byte_t;

    // sample ticks per bit period.
    localparam int OVERSAMPLE = 16;

    // position within one bit period.
    typedef logic [3:0] sample_cnt_t;

endpackage

/* src/cmd_pkg.sv */
package cmd_pkg;

    // ==========================================================
    // command side
    // ==========================================================

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_BAD
    } opcode_t;

    typedef logic [7:0] reg_addr_t;    // raw address byte.
    typedef logic [7:0] reg_data_t;

    localparam int NUM_REGS = 16;

    // protocol bytes.
    localparam logic [7:0] BYTE_WRITE = 8'h57;
    localparam logic [7:0] BYTE_READ  = 8'h52;
    localparam logic [7:0] RSP_ACK    = 8'h4B;
    localparam logic [7:0] RSP_ERR    = 8'h45;

    typedef enum logic [1:0] {
        ST_OK_WRITE,
        ST_OK_READ,
        ST_ERR
    } status_t;

endpackage

/* src/cmd_if.sv */
`timescale 1ns/100ps

interface cmd_if;
    import cmd_pkg::*;

    logic      valid;
    logic      ready;
    opcode_t   opcode;
    reg_addr_t addr;
    reg_data_t wdata;    // only meaningful for writes.

    modport source (
        output valid,
        output opcode,
        output addr,
        output wdata,
        input  ready
    );

    modport sink (
        input  valid,
        input  opcode,
        input  addr,
        input  wdata,
        output ready
    );

endinterface

/* src/rsp_if.sv */
`timescale 1ns/100ps

interface rsp_if;
    import cmd_pkg::*;

    logic      valid;
    logic      ready;
    status_t   status;
    reg_data_t rdata;    // read value, don't care otherwise.

    modport source (
        output valid,
        output status,
        output rdata,
        input  ready
    );

    modport sink (
        input  valid,
        input  status,
        input  rdata,
        output ready
    );

endinterface

/* src/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
    parameter int CLK_DIV = 27
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 rx,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_valid
);
    import uart_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam sample_cnt_t HALF_BIT  = sample_cnt_t'(OVERSAMPLE / 2 - 1);
    localparam sample_cnt_t LAST_TICK = sample_cnt_t'(OVERSAMPLE - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic             rx_s;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    sample_cnt_t      sample_cnt;
    logic [2:0]       bit_cnt;

    assign rx_s = rx_sync[1];
    assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= 2'b11;    // line idles high.
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    // divider restarts with each frame so ticks line up with the start edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (state == IDLE || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==========================================================
    // frame FSM
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                IDLE: begin
                    sample_cnt <= '0;
                    bit_cnt    <= '0;
                    if (!rx_s) state <= START;
                end
                START: if (tick) begin
                    if (sample_cnt == HALF_BIT) begin
                        sample_cnt <= '0;
                        state      <= rx_s ? IDLE : DATA;    // reject glitches.
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                    end
                end
                DATA: if (tick) begin
                    sample_cnt <= sample_cnt + 1'b1;    // wraps each bit.
                    if (sample_cnt == LAST_TICK) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= STOP;
                    end
                end
                STOP: if (tick) begin
                    sample_cnt <= sample_cnt + 1'b1;
                    if (sample_cnt == LAST_TICK) begin
                        rx_valid <= rx_s;    // bad stop bit drops the byte.
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb first, sampled at bit centre.
    always_ff @(posedge clk) begin
        if (state == DATA && tick && sample_cnt == LAST_TICK) begin
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
    end

endmodule

/* src/cmd_decode.sv */
`timescale 1ns/100ps

module cmd_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  uart_pkg::uart_byte_t rx_byte,
    input  logic                 rx_valid,
    cmd_if.source                cmd
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {WAIT_OP, WAIT_ADDR, WAIT_DATA, HOLD} parse_state_t;

    parse_state_t state;
    opcode_t      op_class;

    always_comb begin
        if (rx_byte == BYTE_WRITE) begin
            op_class = OP_WRITE;
        end else if (rx_byte == BYTE_READ) begin
            op_class = OP_READ;
        end else begin
            op_class = OP_BAD;
        end
    end

    assign cmd.valid = (state == HOLD);

    // ==========================================================
    // parse FSM
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= WAIT_OP;
        end else begin
            case (state)
                WAIT_OP: if (rx_valid) begin
                    // unknown opcode is answered right away.
                    state <= (op_class == OP_BAD) ? HOLD : WAIT_ADDR;
                end
                WAIT_ADDR: if (rx_valid) begin
                    state <= (cmd.opcode == OP_WRITE) ? WAIT_DATA : HOLD;
                end
                WAIT_DATA: if (rx_valid) begin
                    state <= HOLD;
                end
                HOLD: if (cmd.ready) begin
                    state <= WAIT_OP;    // bytes seen while holding are lost.
                end
                default: state <= WAIT_OP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                WAIT_OP:   cmd.opcode <= op_class;
                WAIT_ADDR: cmd.addr   <= rx_byte;
                WAIT_DATA: cmd.wdata  <= rx_byte;
                default: ;
            endcase
        end
    end

endmodule

/* src/reg_execute.sv */
`timescale 1ns/100ps

module reg_execute (
    input  logic  clk,
    input  logic  arst_n,
    cmd_if.sink   cmd,
    rsp_if.source rsp
);
    import cmd_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    reg_data_t        regs [NUM_REGS];
    logic             in_range;
    logic [IDX_W-1:0] idx;
    logic             fire;

    assign in_range  = (cmd.addr < reg_addr_t'(NUM_REGS));
    assign idx       = cmd.addr[IDX_W-1:0];
    assign cmd.ready = !rsp.valid;    // one result held at a time.
    assign fire      = cmd.valid && cmd.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp.valid <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (fire) begin
                rsp.valid <= 1'b1;
            end else if (rsp.ready) begin
                rsp.valid <= 1'b0;
            end
            if (fire && in_range && cmd.opcode == OP_WRITE) begin
                regs[idx] <= cmd.wdata;
            end
        end
    end

    // result payload.
    always_ff @(posedge clk) begin
        if (fire) begin
            rsp.rdata <= regs[idx];
            if (!in_range || cmd.opcode == OP_BAD) begin
                rsp.status <= ST_ERR;
            end else if (cmd.opcode == OP_WRITE) begin
                rsp.status <= ST_OK_WRITE;
            end else begin
                rsp.status <= ST_OK_READ;
            end
        end
    end

endmodule

/* src/rsp_format.sv */
`timescale 1ns/100ps

module rsp_format (
    input  logic                 clk,
    input  logic                 arst_n,
    rsp_if.sink                  rsp,
    output uart_pkg::uart_byte_t tx_byte,
    output logic                 tx_valid,
    input  logic                 tx_ready
);
    import cmd_pkg::*;

    reg_data_t rsp_byte;
    logic      take;

    assign rsp.ready = !tx_valid;    // buffer empty.
    assign take      = rsp.valid && rsp.ready;

    always_comb begin
        case (rsp.status)
            ST_OK_WRITE: rsp_byte = RSP_ACK;
            ST_OK_READ:  rsp_byte = rsp.rdata;
            default:     rsp_byte = RSP_ERR;
        endcase
    end

    // ==========================================================
    // one-byte buffer toward the transmitter
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_valid <= 1'b0;
        end else if (take) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            tx_byte <= rsp_byte;
        end
    end

endmodule

/* src/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLK_DIV = 27
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 tx
);
    import uart_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam sample_cnt_t LAST_TICK = sample_cnt_t'(OVERSAMPLE - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

    tx_state_t        state;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    sample_cnt_t      sample_cnt;
    logic             bit_done;
    logic [2:0]       bit_cnt;
    uart_byte_t       shift;

    assign tx_ready = (state == IDLE);
    assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign bit_done = tick && (sample_cnt == LAST_TICK);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else if (state == IDLE || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            tx         <= 1'b1;
        end else begin
            if (state == IDLE) begin
                sample_cnt <= '0;
                bit_cnt    <= '0;
            end else if (tick) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            case (state)
                IDLE: if (tx_valid) begin
                    state <= START;
                    tx    <= 1'b0;    // start bit.
                end
                START: if (bit_done) begin
                    state <= DATA;
                    tx    <= shift[0];
                end
                DATA: if (bit_done) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= STOP;
                        tx    <= 1'b1;
                    end else begin
                        tx <= shift[1];
                    end
                end
                STOP: if (bit_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            shift <= tx_byte;
        end else if (state == DATA && bit_done) begin
            shift <= shift >> 1;
        end
    end

endmodule

/* src/uart_cmd_top.sv */
`timescale 1ns/100ps

module uart_cmd_top #(
    parameter int CLK_DIV = 27    // 50 MHz, 115200 baud.
) (
    input  logic clk,
    input  logic arst_n,
    input  logic rx,
    output logic tx
);
    import uart_pkg::*;

    uart_byte_t rx_byte;
    logic       rx_valid;
    uart_byte_t tx_byte;
    logic       tx_valid;
    logic       tx_ready;

    cmd_if cmd_link ();
    rsp_if rsp_link ();

    // ==========================================================
    // rx -> decode -> execute -> format -> tx
    // ==========================================================
    uart_rx #(.CLK_DIV(CLK_DIV)) u_uart_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    cmd_decode u_cmd_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .cmd      (cmd_link.source)
    );

    reg_execute u_reg_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (cmd_link.sink),
        .rsp    (rsp_link.source)
    );

    rsp_format u_rsp_format (
        .clk      (clk),
        .arst_n   (arst_n),
        .rsp      (rsp_link.sink),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    uart_tx #(.CLK_DIV(CLK_DIV)) u_uart_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

endmodule

/* test/uart_monitor.sv */
`timescale 1ns/100ps

module uart_monitor #(
    parameter int BIT_CLKS = 32
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rx,
    input  logic       tx,
    input  logic [7:0] exp_rsp,
    output int         rsp_count,
    output int         err_count
);

    logic [7:0] model [16];
    logic [7:0] predict_q [$];
    int         rx_errs;
    int         tx_errs;

    assign err_count = rx_errs + tx_errs;

    function automatic logic line_level(input bit use_tx);
        return use_tx ? tx : rx;
    endfunction

    // entered at the first low sample of a frame.
    task automatic read_frame(input bit use_tx, output logic [7:0] data, output logic framed);
        repeat (BIT_CLKS / 2) @(negedge clk);
        framed = !line_level(use_tx);    // start bit still low at mid-bit.
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = line_level(use_tx);
        end
        repeat (BIT_CLKS) @(negedge clk);
        framed = framed && line_level(use_tx);
    endtask

    // ==========================================================
    // host side: parse commands, predict responses
    // ==========================================================
    initial begin : rx_side
        logic [7:0] b;
        logic       good;
        logic [7:0] op;
        logic [7:0] addr;
        int         step;
        rx_errs = 0;
        step    = 0;
        for (int i = 0; i < 16; i++) begin
            model[i] = 8'h00;
        end
        forever begin
            @(negedge clk);
            if (arst_n && rx === 1'b0) begin
                read_frame(1'b0, b, good);
                if (!good) begin
                    rx_errs++;
                    $display("%0t: a command frame on rx is malformed", $time);
                end else if (step == 0) begin
                    op = b;
                    if (b == 8'h57 || b == 8'h52) begin
                        step = 1;
                    end else begin
                        predict_q.push_back(8'h45);    // unknown opcode.
                    end
                end else if (step == 1) begin
                    addr = b;
                    if (op == 8'h57) begin
                        step = 2;
                    end else begin
                        predict_q.push_back((addr < 8'd16) ? model[addr[3:0]] : 8'h45);
                        step = 0;
                    end
                end else begin
                    if (addr < 8'd16) begin
                        model[addr[3:0]] = b;
                        predict_q.push_back(8'h4B);
                    end else begin
                        predict_q.push_back(8'h45);
                    end
                    step = 0;
                end
            end
        end
    end

    // ==========================================================
    // response side
    // ==========================================================
    initial begin : tx_side
        logic [7:0] b;
        logic       good;
        logic [7:0] want;
        tx_errs   = 0;
        rsp_count = 0;
        forever begin
            @(negedge clk);
            if (arst_n && tx === 1'b0) begin
                read_frame(1'b1, b, good);
                if (!good) begin
                    tx_errs++;
                    $display("%0t: response frame has a bad start or stop bit", $time);
                end
                if (predict_q.size() == 0) begin
                    tx_errs++;
                    $display("%0t: tx sent a byte that no command asked for", $time);
                end else begin
                    want = predict_q.pop_front();
                    if (b !== want) begin
                        tx_errs++;
                        $display("FAIL %0t tx_byte expected %02h actual %02h", $time, want, b);
                    end
                end
                if (b !== exp_rsp) begin
                    tx_errs++;
                    $display("FAIL %0t tx_byte expected %02h actual %02h (table)",
                             $time, exp_rsp, b);
                end
                rsp_count++;
            end else if (tx !== 1'b1) begin
                tx_errs++;
                $display("%0t: tx is not idle high", $time);
            end
        end
    end

endmodule

/* test/tb_uart_cmd.sv */
`timescale 1ns/100ps

module tb_uart_cmd;

    localparam int BIT_CLKS  = 32;
    localparam int WAIT_CLKS = 2000;    // bound for one response.

    logic        clk;
    logic        arst_n;
    logic        rx;
    logic        tx;
    logic [7:0]  exp_rsp;
    int          rsp_count;
    int          err_count;
    int          timeouts;
    logic [31:0] lcg_state;

    logic [7:0] tab_op   [$];
    logic [7:0] tab_addr [$];
    logic [7:0] tab_data [$];
    logic [7:0] tab_exp  [$];
    logic [7:0] model    [16];

    uart_cmd_top #(.CLK_DIV(2)) UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .rx     (rx),
        .tx     (tx)
    );

    uart_monitor #(.BIT_CLKS(BIT_CLKS)) u_monitor (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .tx        (tx),
        .exp_rsp   (exp_rsp),
        .rsp_count (rsp_count),
        .err_count (err_count)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[23:16];
    endfunction

    // appends one row; the expected byte comes from the table's own model.
    task automatic add_row(input logic [7:0] op, input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] rsp;
        rsp = 8'h45;
        if (op == 8'h57 && addr < 8'd16) begin
            model[addr[3:0]] = data;
            rsp = 8'h4B;
        end else if (op == 8'h52 && addr < 8'd16) begin
            rsp = model[addr[3:0]];
        end
        tab_op.push_back(op);
        tab_addr.push_back(addr);
        tab_data.push_back(data);
        tab_exp.push_back(rsp);
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};    // stop, data lsb first, start.
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 rx = frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic send_row(input int r);
        send_byte(tab_op[r]);
        if (tab_op[r] == 8'h57 || tab_op[r] == 8'h52) begin
            send_byte(tab_addr[r]);
        end
        if (tab_op[r] == 8'h57) begin
            send_byte(tab_data[r]);
        end
    endtask

    initial begin
        int waited;
        clk       = 1'b0;
        arst_n    = 1'b0;
        rx        = 1'b1;
        exp_rsp   = 8'h00;
        timeouts  = 0;
        lcg_state = 32'h844d;
        for (int i = 0; i < 16; i++) begin
            model[i] = 8'h00;
        end

        // ==========================================================
        // stimulus table
        // ==========================================================
        add_row(8'h52, 8'h00, 8'h00);    // reads after reset.
        add_row(8'h52, 8'h07, 8'h00);
        add_row(8'h52, 8'h0F, 8'h00);
        add_row(8'h57, 8'h03, 8'hA5);
        add_row(8'h52, 8'h03, 8'h00);
        add_row(8'h57, 8'h09, lcg_byte());
        add_row(8'h52, 8'h09, 8'h00);
        for (int a = 0; a < 16; a++) begin
            add_row(8'h57, 8'(a), lcg_byte());
        end
        for (int a = 0; a < 16; a++) begin
            add_row(8'h52, 8'(a), 8'h00);
        end
        add_row(8'h57, 8'h10, 8'hFF);    // out of range.
        add_row(8'h57, 8'hF3, 8'h00);
        add_row(8'h52, 8'h10, 8'h00);
        add_row(8'h52, 8'h03, 8'h00);
        add_row(8'h52, 8'h00, 8'h00);
        add_row(8'h00, 8'h00, 8'h00);    // unknown opcodes.
        add_row(8'hA5, 8'h00, 8'h00);
        add_row(8'h52, 8'h03, 8'h00);
        add_row(8'h57, 8'h0C, lcg_byte());
        add_row(8'h52, 8'h0C, 8'h00);

        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (BIT_CLKS) @(posedge clk);

        for (int r = 0; r < tab_op.size() && timeouts == 0; r++) begin
            exp_rsp = tab_exp[r];
            send_row(r);
            waited = 0;
            while (rsp_count < r + 1 && waited < WAIT_CLKS) begin
                @(posedge clk);
                waited++;
            end
            if (rsp_count < r + 1) begin
                timeouts++;
                $display("%0t: no response arrived for table row %0d", $time, r);
            end
        end

        $display("errors: %0d  timeouts: %0d", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
src/uart_pkg.sv
src/cmd_pkg.sv
src/cmd_if.sv
src/rsp_if.sv
src/uart_rx.sv
src/cmd_decode.sv
src/reg_execute.sv
src/rsp_format.sv
src/uart_tx.sv
src/uart_cmd_top.sv
test/uart_monitor.sv
test/tb_uart_cmd.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_uart_cmd -f sim.f -o tb_uart_cmd \
    && ./obj_dir/tb_uart_cmd > sim.log 2>&1 \
    && grep -q "SIMULATION PASSED" sim.log \
    && echo "run passed" \
    || { echo "run failed, see sim.log"; exit 1; }
